//--- dv/tb_tk1_core.sv
// Table-driven testbench for the tk1 control and security core
`timescale 1ns/1ps

module tb_tk1_core;

  typedef enum logic [2:0] {
    k_reset,
    k_read,
    k_write,
    k_cpu,
    k_gpio,
    k_led,
    k_ctrl
  } kind_e;

  // One table step, with the CPU address in addr and the fetch flag in data[0] for k_cpu
  typedef struct packed {
    kind_e       kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
  } row_t;

  logic                     clk;
  logic                     reset_n;
  logic                     cpu_trap;
  logic                     gpio1;
  logic                     gpio2;
  tk1_cpu_pkg::cpu_access_t cpu;
  tk1_map_pkg::reg_req_t    req;
  logic [31:0]              read_data;
  logic                     ready;
  logic                     fw_app_mode;
  logic                     force_trap;
  logic                     system_reset;
  tk1_map_pkg::led_t        led;
  logic                     gpio3;
  logic                     gpio4;

  integer      seed;
  logic [31:0] words [12];
  logic [31:0] tmp;
  logic [2:0]  led_val;
  logic        red_start;
  row_t        rows [$];

  tk1_core #(
    .blink_width (4)
  ) u_tk1_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .cpu_trap     (cpu_trap),
    .cpu          (cpu),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .req          (req),
    .read_data    (read_data),
    .ready        (ready),
    .fw_app_mode  (fw_app_mode),
    .force_trap   (force_trap),
    .system_reset (system_reset),
    .led          (led),
    .gpio3        (gpio3),
    .gpio4        (gpio4)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_led(input string name, input tk1_map_pkg::led_t got,
                           input tk1_map_pkg::led_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] reg_word(input tk1_map_pkg::reg_addr_e a);
    return {24'h0, a};
  endfunction

  task automatic add_row(input kind_e kind, input logic [31:0] addr,
                         input logic [31:0] data, input logic [31:0] expected);
    rows.push_back('{kind: kind, addr: addr, data: data, expected: expected});
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
  endtask

  task automatic apply_row(input row_t r);
    @(negedge clk);
    req = '0;   // Idle bus unless the row drives it
    cpu = '0;
    case (r.kind)
      k_reset: apply_reset();
      k_read: begin
        req = '{cs: 1'b1, we: 1'b0, address: r.addr[7:0], write_data: 32'h0};
        #10;
        check_bit("ready", ready, 1'b1);
        check_word("read_data", read_data, r.expected);
      end
      k_write: req = '{cs: 1'b1, we: 1'b1, address: r.addr[7:0], write_data: r.data};
      k_cpu: begin
        cpu = '{valid: 1'b1, instr: r.data[0], addr: r.addr};
        @(negedge clk);
        cpu = '0;
        #10 check_bit("force_trap", force_trap, r.expected[0]);
      end
      k_gpio: begin
        gpio1 = r.data[0];
        gpio2 = r.data[1];
        repeat (3) @(negedge clk);  // Past the two synchroniser flops
      end
      k_led: #10 check_led("led", led, r.expected[2:0]);
      default: begin
        #10;
        check_bit("fw_app_mode", fw_app_mode, r.expected[4]);
        check_bit("force_trap", force_trap, r.expected[3]);
        check_bit("system_reset", system_reset, r.expected[2]);
        check_bit("gpio3", gpio3, r.expected[1]);
        check_bit("gpio4", gpio4, r.expected[0]);
      end
    endcase
  endtask

  // Waits for the red blink bit to leave old_r while g and b stay clear
  task automatic wait_red_change(input logic old_r);
    int cycles;
    cycles = 0;
    while (led.r === old_r && cycles < 20) begin
      @(negedge clk);
      #10;
      check_bit("led.g", led.g, 1'b0);
      check_bit("led.b", led.b, 1'b0);
      cycles++;
    end
    if (led.r === old_r) begin
      report_timeout("red blink bit did not change within 20 cycles");
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    reset_n  = 1'b0;
    cpu_trap = 1'b0;
    gpio1    = 1'b0;
    gpio2    = 1'b0;
    cpu      = '0;
    req      = '0;
    seed     = 85;
    for (int i = 0; i < 12; i++) begin
      words[i] = $random(seed);
    end
    tmp     = $random(seed);
    led_val = tmp[2:0];

    // Reset state and identity
    add_row(k_reset, 32'h0, 32'h0, 32'h0);
    add_row(k_read, reg_word(tk1_map_pkg::name0), 32'h0, 32'h746b3120);
    add_row(k_read, reg_word(tk1_map_pkg::name1), 32'h0, 32'h6d6b6466);
    add_row(k_read, reg_word(tk1_map_pkg::version), 32'h0, 32'h00000005);
    add_row(k_led, 32'h0, 32'h0, 32'h6);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h00);

    // Register write and read back
    add_row(k_write, reg_word(tk1_map_pkg::app_start), words[0], 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::app_size), words[1], 32'h0);
    for (int i = 0; i < 8; i++) begin
      add_row(k_write, reg_word(tk1_map_pkg::cdi_first) + i, words[2+i], 32'h0);
    end
    add_row(k_read, reg_word(tk1_map_pkg::app_start), 32'h0, words[0]);
    add_row(k_read, reg_word(tk1_map_pkg::app_size), 32'h0, words[1]);
    for (int i = 0; i < 8; i++) begin
      add_row(k_read, reg_word(tk1_map_pkg::cdi_first) + i, 32'h0, words[2+i]);
    end
    add_row(k_write, reg_word(tk1_map_pkg::led), {29'h0, led_val}, 32'h0);
    add_row(k_led, 32'h0, 32'h0, {29'h0, led_val});
    add_row(k_read, reg_word(tk1_map_pkg::led), 32'h0, {29'h0, led_val});
    add_row(k_write, reg_word(tk1_map_pkg::gpio), 32'hc, 32'h0);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h03);
    add_row(k_gpio, 32'h0, 32'h1, 32'h0);
    add_row(k_read, reg_word(tk1_map_pkg::gpio), 32'h0, 32'hd);
    add_row(k_gpio, 32'h0, 32'h2, 32'h0);
    add_row(k_read, reg_word(tk1_map_pkg::gpio), 32'h0, 32'he);
    add_row(k_read, 32'h05, 32'h0, 32'h0);
    add_row(k_read, 32'hff, 32'h0, 32'h0);

    // Application mode freezes app and CDI registers
    add_row(k_write, reg_word(tk1_map_pkg::switch_app), 32'h0, 32'h0);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h13);
    add_row(k_read, reg_word(tk1_map_pkg::switch_app), 32'h0, 32'hffffffff);
    add_row(k_write, reg_word(tk1_map_pkg::app_start), words[10], 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::cdi_first) + 5, words[11], 32'h0);
    add_row(k_read, reg_word(tk1_map_pkg::app_start), 32'h0, words[0]);
    add_row(k_read, reg_word(tk1_map_pkg::cdi_first) + 5, 32'h0, words[7]);
    add_row(k_write, reg_word(tk1_map_pkg::led), {29'h0, ~led_val}, 32'h0);
    add_row(k_led, 32'h0, 32'h0, {29'h0, ~led_val});

    // Security monitor
    add_row(k_reset, 32'h0, 32'h0, 32'h0);
    add_row(k_cpu, 32'hd0000100, 32'h0, 32'h0);  // Data read of firmware RAM is fine
    add_row(k_cpu, 32'h4001fffc, 32'h1, 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::mon_first), 32'h40001000, 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::mon_last), 32'h40001fff, 32'h0);
    add_row(k_cpu, 32'h40001800, 32'h1, 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::mon_ctrl), 32'h1, 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::mon_first), 32'h40008000, 32'h0);
    add_row(k_write, reg_word(tk1_map_pkg::mon_last), 32'h40008fff, 32'h0);
    add_row(k_cpu, 32'h40008800, 32'h1, 32'h0);
    add_row(k_cpu, 32'h40001800, 32'h1, 32'h1);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h08);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h08);
    add_row(k_reset, 32'h0, 32'h0, 32'h0);
    add_row(k_cpu, 32'hd0000010, 32'h1, 32'h1);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h08);
    add_row(k_reset, 32'h0, 32'h0, 32'h0);
    add_row(k_cpu, 32'h40020000, 32'h0, 32'h1);
    add_row(k_ctrl, 32'h0, 32'h0, 32'h08);

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    // System reset pulse, high for exactly the cycle after the write
    @(negedge clk);
    req = '{cs: 1'b1, we: 1'b1, address: tk1_map_pkg::system_reset, write_data: 32'h1};
    #10 check_bit("system_reset", system_reset, 1'b0);
    @(negedge clk);
    req = '0;
    #10 check_bit("system_reset", system_reset, 1'b1);
    @(negedge clk);
    #10 check_bit("system_reset", system_reset, 1'b0);

    // Trap blink overrides the LED register
    @(negedge clk);
    req = '{cs: 1'b1, we: 1'b1, address: tk1_map_pkg::led, write_data: 32'h5};
    @(negedge clk);
    req      = '0;
    cpu_trap = 1'b1;
    #10;
    check_bit("led.g", led.g, 1'b0);
    check_bit("led.b", led.b, 1'b0);
    red_start = led.r;
    wait_red_change(red_start);
    wait_red_change(~red_start);
    @(negedge clk);
    cpu_trap = 1'b0;
    #10 check_led("led", led, 3'h5);

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- hdl/security_monitor.sv
// Execution window registers and sticky force_trap on access violations
`timescale 1ns/1ps

module security_monitor (
  input  logic                     clk,
  input  logic                     reset_n,
  input  tk1_map_pkg::reg_req_t    req,
  input  logic                     mon_locked,
  input  tk1_cpu_pkg::cpu_access_t cpu,
  output logic                     force_trap
);

  logic [31:0] win_first_q;
  logic [31:0] win_last_q;
  logic        force_trap_q;

  logic win_wr;
  logic ram_oob;
  logic fw_exec;
  logic win_exec;
  logic trap_set;

  // Window is writable until the monitor is locked
  assign win_wr = req.cs && req.we && !mon_locked;

  always_ff @(posedge clk) begin
    if (win_wr && req.address == tk1_map_pkg::mon_first) begin
      win_first_q <= req.write_data;
    end
    if (win_wr && req.address == tk1_map_pkg::mon_last) begin
      win_last_q <= req.write_data;
    end
  end

  // ------------------------------------------------------------------------
  // Violation checks
  // ------------------------------------------------------------------------
  assign ram_oob = (cpu.addr[31:30] == tk1_cpu_pkg::RAM_PREFIX) &&
                   (|cpu.addr[29:tk1_cpu_pkg::RAM_PHYS_BITS]);

  assign fw_exec = cpu.instr &&
                   (cpu.addr >= tk1_cpu_pkg::FW_RAM_FIRST) &&
                   (cpu.addr <= tk1_cpu_pkg::FW_RAM_LAST);

  assign win_exec = cpu.instr && mon_locked &&
                    (cpu.addr >= win_first_q) && (cpu.addr <= win_last_q);

  assign trap_set = cpu.valid && (ram_oob || fw_exec || win_exec);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap_q <= 1'b0;
    end else if (trap_set) begin
      force_trap_q <= 1'b1;  // Held until reset
    end
  end

  assign force_trap = force_trap_q;

  a_trap_sticky : assert property (
    @(posedge clk) disable iff (!reset_n) force_trap |=> force_trap
  );

endmodule

//--- hdl/tk1_core.sv
// tk1 control and security core tying mode control, registers and monitor together
`timescale 1ns/1ps

module tk1_core #(
  parameter int blink_width = tk1_map_pkg::BLINK_WIDTH
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     cpu_trap,
  input  tk1_cpu_pkg::cpu_access_t cpu,
  input  logic                     gpio1,
  input  logic                     gpio2,
  input  tk1_map_pkg::reg_req_t    req,
  output logic [31:0]              read_data,
  output logic                     ready,
  output logic                     fw_app_mode,
  output logic                     force_trap,
  output logic                     system_reset,
  output tk1_map_pkg::led_t        led,
  output logic                     gpio3,
  output logic                     gpio4
);

  logic              mon_locked;
  tk1_map_pkg::led_t blink;

  tk1_mode_fsm u_mode_fsm (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req),
    .app_mode     (fw_app_mode),
    .mon_locked   (mon_locked),
    .system_reset (system_reset)
  );

  trap_blink_timer #(
    .width (blink_width)
  ) u_blink_timer (
    .clk     (clk),
    .reset_n (reset_n),
    .blink   (blink)
  );

  tk1_regs u_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (req),
    .app_mode  (fw_app_mode),
    .cpu_trap  (cpu_trap),
    .gpio1     (gpio1),
    .gpio2     (gpio2),
    .blink     (blink),
    .read_data (read_data),
    .ready     (ready),
    .gpio3     (gpio3),
    .gpio4     (gpio4),
    .led       (led)
  );

  security_monitor u_monitor (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (req),
    .mon_locked (mon_locked),
    .cpu        (cpu),
    .force_trap (force_trap)
  );

endmodule

//--- hdl/tk1_cpu_pkg.sv
// CPU bus view and memory region constants used by the security monitor
package tk1_cpu_pkg;

  // ------------------------------------------------------------------------
  // CPU access as seen on the memory bus
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic        valid;
    logic        instr;  // Instruction fetch
    logic [31:0] addr;
  } cpu_access_t;

  // ------------------------------------------------------------------------
  // Memory regions
  // ------------------------------------------------------------------------

  // Firmware RAM, never executable
  localparam logic [31:0] FW_RAM_FIRST = 32'hd0000000;
  localparam logic [31:0] FW_RAM_LAST  = 32'hd00007ff;

  // Main RAM is selected by addr[31:30]
  localparam logic [1:0] RAM_PREFIX = 2'b01;

  // Physical RAM is 128 KiB, so bits 29 down to 17 must be clear
  localparam int RAM_PHYS_BITS = 17;

endpackage

//--- hdl/tk1_map_pkg.sv
// tk1 register map package with addresses, identity words and register port types
package tk1_map_pkg;

  // ------------------------------------------------------------------------
  // Register addresses
  // ------------------------------------------------------------------------
  typedef enum logic [7:0] {
    name0        = 8'h00,
    name1        = 8'h01,
    version      = 8'h02,
    switch_app   = 8'h08,
    led          = 8'h09,
    gpio         = 8'h0a,
    app_start    = 8'h0c,
    app_size     = 8'h0d,
    cdi_first    = 8'h20,   // CDI store spans 0x20..0x27
    cdi_last     = 8'h27,
    mon_ctrl     = 8'h60,
    mon_first    = 8'h61,
    mon_last     = 8'h62,
    system_reset = 8'h70
  } reg_addr_e;

  // ------------------------------------------------------------------------
  // Port types
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic        cs;
    logic        we;
    logic [7:0]  address;
    logic [31:0] write_data;
  } reg_req_t;

  // r is bit 2, g bit 1, b bit 0
  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } led_t;

  // ------------------------------------------------------------------------
  // Constants
  // ------------------------------------------------------------------------
  localparam logic [31:0] NAME0   = 32'h746b3120;  // "tk1 "
  localparam logic [31:0] NAME1   = 32'h6d6b6466;  // "mkdf"
  localparam logic [31:0] VERSION = 32'h00000005;

  localparam led_t LED_RESET = '{r: 1'b1, g: 1'b1, b: 1'b0};

  localparam int CDI_WORDS   = 8;
  localparam int BLINK_WIDTH = 24;  // Roughly 0.7 s half period at 24 MHz

endpackage

//--- hdl/tk1_mode_fsm.sv
// Mode and monitor lock state machines plus the system reset pulse
`timescale 1ns/1ps

module tk1_mode_fsm (
  input  logic                  clk,
  input  logic                  reset_n,
  input  tk1_map_pkg::reg_req_t req,
  output logic                  app_mode,
  output logic                  mon_locked,
  output logic                  system_reset
);

  typedef enum logic {
    fw_mode_st,
    app_mode_st
  } mode_e;

  typedef enum logic {
    mon_open_st,
    mon_locked_st
  } lock_e;

  mode_e mode_q;
  lock_e lock_q;
  logic  system_reset_q;
  logic  wr;

  assign wr = req.cs && req.we;

  // ------------------------------------------------------------------------
  // State registers, both one-way until reset
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mode_q         <= fw_mode_st;
      lock_q         <= mon_open_st;
      system_reset_q <= 1'b0;
    end else begin
      case (mode_q)
        fw_mode_st: if (wr && req.address == tk1_map_pkg::switch_app) mode_q <= app_mode_st;
        default:    mode_q <= app_mode_st;
      endcase

      case (lock_q)
        mon_open_st: if (wr && req.address == tk1_map_pkg::mon_ctrl) lock_q <= mon_locked_st;
        default:     lock_q <= mon_locked_st;
      endcase

      // One cycle pulse after the write
      system_reset_q <= wr && (req.address == tk1_map_pkg::system_reset);
    end
  end

  assign app_mode     = (mode_q == app_mode_st);
  assign mon_locked   = (lock_q == mon_locked_st);
  assign system_reset = system_reset_q;

  // ------------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------------
  a_app_mode_sticky : assert property (
    @(posedge clk) disable iff (!reset_n) app_mode |=> app_mode
  );

  // A reset request cannot be stretched by back-to-back pulses
  a_reset_single : assert property (
    @(posedge clk) disable iff (!reset_n) system_reset |=> !system_reset
  );

endmodule

//--- hdl/tk1_regs.sv
// Register file with GPIO synchronisers, LED select and read data mux
`timescale 1ns/1ps

module tk1_regs (
  input  logic                  clk,
  input  logic                  reset_n,
  input  tk1_map_pkg::reg_req_t req,
  input  logic                  app_mode,
  input  logic                  cpu_trap,
  input  logic                  gpio1,
  input  logic                  gpio2,
  input  tk1_map_pkg::led_t     blink,
  output logic [31:0]           read_data,
  output logic                  ready,
  output logic                  gpio3,
  output logic                  gpio4,
  output tk1_map_pkg::led_t     led
);

  tk1_map_pkg::led_t led_q;
  logic              gpio3_q;
  logic              gpio4_q;
  logic [1:0]        gpio1_sync;
  logic [1:0]        gpio2_sync;
  logic [31:0]       app_start_q;
  logic [31:0]       app_size_q;
  logic [31:0]       cdi_mem [tk1_map_pkg::CDI_WORDS];

  logic wr;
  logic rd;
  logic cdi_hit;

  assign wr = req.cs && req.we;
  assign rd = req.cs && !req.we;

  assign cdi_hit = (req.address >= tk1_map_pkg::cdi_first) &&
                   (req.address <= tk1_map_pkg::cdi_last);

  // ------------------------------------------------------------------------
  // Control registers and GPIO synchronisers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_q      <= tk1_map_pkg::LED_RESET;
      gpio3_q    <= 1'b0;
      gpio4_q    <= 1'b0;
      gpio1_sync <= 2'b00;
      gpio2_sync <= 2'b00;
    end else begin
      gpio1_sync <= {gpio1_sync[0], gpio1};  // Two flops per input
      gpio2_sync <= {gpio2_sync[0], gpio2};

      if (wr && req.address == tk1_map_pkg::led) begin
        led_q <= req.write_data[2:0];
      end

      if (wr && req.address == tk1_map_pkg::gpio) begin
        gpio3_q <= req.write_data[2];
        gpio4_q <= req.write_data[3];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Application registers and CDI store, frozen in application mode
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr && !app_mode) begin
      if (req.address == tk1_map_pkg::app_start) begin
        app_start_q <= req.write_data;
      end
      if (req.address == tk1_map_pkg::app_size) begin
        app_size_q <= req.write_data;
      end
      if (cdi_hit) begin
        cdi_mem[req.address[2:0]] <= req.write_data;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read mux, zero latency
  // ------------------------------------------------------------------------
  always_comb begin
    read_data = 32'h0;
    if (rd) begin
      case (req.address)
        tk1_map_pkg::name0:      read_data = tk1_map_pkg::NAME0;
        tk1_map_pkg::name1:      read_data = tk1_map_pkg::NAME1;
        tk1_map_pkg::version:    read_data = tk1_map_pkg::VERSION;
        tk1_map_pkg::switch_app: read_data = {32{app_mode}};
        tk1_map_pkg::led:        read_data = {29'h0, led_q};
        tk1_map_pkg::gpio: begin
          read_data = {28'h0, gpio4_q, gpio3_q, gpio2_sync[1], gpio1_sync[1]};
        end
        tk1_map_pkg::app_start:  read_data = app_start_q;
        tk1_map_pkg::app_size:   read_data = app_size_q;
        default: begin
          if (cdi_hit) begin
            read_data = cdi_mem[req.address[2:0]];
          end
        end
      endcase
    end
  end

  assign ready = req.cs;  // Never stalls
  assign gpio3 = gpio3_q;
  assign gpio4 = gpio4_q;

  // Trap blink overrides the LED register
  assign led = cpu_trap ? blink : led_q;

endmodule

//--- hdl/trap_blink_timer.sv
// Free-running counter that toggles the red trap blink pattern
`timescale 1ns/1ps

module trap_blink_timer #(
  parameter int width = tk1_map_pkg::BLINK_WIDTH
) (
  input  logic              clk,
  input  logic              reset_n,
  output tk1_map_pkg::led_t blink
);

  logic [width-1:0] count_q;
  logic             red_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count_q <= '0;
      red_q   <= 1'b0;
    end else begin
      count_q <= count_q + 1'b1;  // Wraps around
      if (count_q == '0) begin
        red_q <= ~red_q;
      end
    end
  end

  // Only red blinks
  assign blink = '{r: red_q, g: 1'b0, b: 1'b0};

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the tk1 core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_tk1_core -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "^TB PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

//--- tb.f
hdl/tk1_map_pkg.sv
hdl/tk1_cpu_pkg.sv
hdl/tk1_mode_fsm.sv
hdl/trap_blink_timer.sv
hdl/tk1_regs.sv
hdl/security_monitor.sv
hdl/tk1_core.sv
dv/tb_tk1_core.sv
